/* source/amac_macros.svh */
`ifndef AMAC_MACROS_SVH
`define AMAC_MACROS_SVH

// operand width of both multiplier inputs
`define AMAC_OP_W 16

// full-width approximate product
`define AMAC_PROD_W 32

// accumulator and result width, wraps modulo 2^40
`define AMAC_ACC_W 40

// product FIFO entries, power of two and at least 2
`define AMAC_FIFO_DEPTH 4

`endif

/* source/amac_arith_pkg.sv */
`default_nettype none

`include "amac_macros.svh"

package amac_arith_pkg;

    // two's complement multiplier input
    typedef logic signed [`AMAC_OP_W-1:0] operand_t;

    // approximate product as returned by the multiplier
    typedef logic signed [`AMAC_PROD_W-1:0] product_t;

    // running sum, also the result value
    typedef logic signed [`AMAC_ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

/* source/amac_xfer_pkg.sv */
`default_nettype none

package amac_xfer_pkg;

    // what the back end does with a product
    typedef enum logic {
        OP_MUL = 1'b0,
        OP_MAC = 1'b1
    } opcode_e;

    // command word on the input port
    typedef struct packed {
        opcode_e                  opcode;
        amac_arith_pkg::operand_t x;
        amac_arith_pkg::operand_t y;
    } cmd_t;

    // fifo word between front and back end
    typedef struct packed {
        opcode_e                  opcode;
        amac_arith_pkg::product_t product;
    } entry_t;

    // result word on the output port
    typedef struct packed {
        amac_arith_pkg::acc_t value;
        opcode_e              opcode;
    } result_t;

endpackage

`default_nettype wire

/* source/approx_signed_mult.sv */
`default_nettype none

module approx_signed_mult (
    input  wire amac_arith_pkg::operand_t x,
    input  wire amac_arith_pkg::operand_t y,
    output amac_arith_pkg::product_t      z
);

    // one baugh-wooley row per bit of x
    logic [15:0] pp [16];

    // approximate compression of the low rows
    logic [20:0] corr [4];

    logic [31:0] sum;

    always_comb begin
        for (int i = 0; i < 15; i++) begin
            pp[i][14:0] = y[14:0] & {15{x[i]}};
            pp[i][15]   = ~(y[15] & x[i]);
        end
        // sign row of x, magnitude terms inverted
        pp[15][14:0] = ~(y[14:0] & {15{x[15]}});
        pp[15][15]   = y[15] & x[15];
    end

    // rows 0..5 never enter the sum directly, only through these terms
    always_comb begin
        corr[0] = '0;
        corr[1] = '0;
        corr[2] = '0;
        corr[3] = '0;

        corr[0][3]  = pp[2][1] ^ pp[3][0];
        corr[0][4]  = pp[0][3] & pp[1][2];
        corr[0][5]  = pp[2][3] ^ pp[3][2];
        corr[0][7]  = pp[2][5] ^ pp[3][4];
        corr[0][9]  = pp[0][8] & pp[1][7];
        corr[0][10] = pp[2][7] & pp[3][6];
        corr[0][11] = pp[0][10] & pp[1][9];
        corr[0][14] = pp[4][9] & pp[5][8];
        corr[0][15] = pp[0][15] ^ pp[1][14];
        corr[0][16] = pp[4][12] ^ pp[5][11];
        // constant one of row 1 absorbed here
        corr[0][17] = pp[1][15];
        corr[0][18] = pp[2][15] & pp[3][14];
        corr[0][19] = pp[4][14] & pp[5][13];
        corr[0][20] = pp[4][15] & pp[5][14];

        corr[1][4]  = pp[2][2] ^ pp[3][1];
        corr[1][9]  = pp[0][9] ^ pp[1][8];
        corr[1][10] = pp[2][8] ^ pp[3][7];
        corr[1][11] = pp[0][11] ^ pp[1][10];
        corr[1][15] = pp[4][10] & pp[5][9];
        corr[1][17] = pp[2][15] ^ pp[3][14];
        corr[1][18] = pp[3][15];
        corr[1][19] = pp[4][15] ^ pp[5][14];
        corr[1][20] = pp[5][15];

        corr[2][9]  = pp[2][7] ^ pp[3][6];
        corr[2][17] = pp[4][13] ^ pp[5][12];
        corr[2][18] = pp[4][13] & pp[5][12];

        corr[3][18] = pp[4][14] ^ pp[5][13];
    end

    always_comb begin
        // top row carries the constant one at bit 31
        sum = {1'b1, pp[15], 15'b0};
        for (int i = 6; i < 15; i++) begin
            sum = sum + (32'(pp[i]) << i);
        end
        for (int k = 0; k < 4; k++) begin
            sum = sum + 32'(corr[k]);
        end
    end

    assign z = sum;

endmodule

`default_nettype wire

/* source/operand_front.sv */
`default_nettype none

module operand_front (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire amac_xfer_pkg::cmd_t cmd,
    input  wire                   cmd_req,
    output logic                  cmd_ack,
    input  wire                   full,
    output logic                  push,
    output amac_xfer_pkg::entry_t push_data
);

    amac_arith_pkg::product_t prod;

    // operands are stable while req is high, so the product is too
    approx_signed_mult u_mult (
        .x (cmd.x),
        .y (cmd.y),
        .z (prod)
    );

    // take a new command only when there is room for its entry
    assign push = cmd_req && !cmd_ack && !full;

    always_comb begin
        push_data.opcode  = cmd.opcode;
        push_data.product = prod;
    end

    // four-phase ack, rises with the push and falls once req is gone
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_ack <= 1'b0;
        end else if (push) begin
            cmd_ack <= 1'b1;
        end else if (!cmd_req) begin
            cmd_ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/product_fifo.sv */
`default_nettype none

`include "amac_macros.svh"

module product_fifo (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      push,
    input  wire amac_xfer_pkg::entry_t push_data,
    output logic                     full,
    input  wire                      pop,
    output amac_xfer_pkg::entry_t    pop_data,
    output logic                     empty
);

    localparam int DEPTH = `AMAC_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    amac_xfer_pkg::entry_t mem [DEPTH];

    // msb of each pointer is the wrap bit
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    logic do_push;
    logic do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign pop_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
        end else if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
        end else if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/accum_back.sv */
`default_nettype none

`include "amac_macros.svh"

module accum_back (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire amac_xfer_pkg::entry_t pop_data,
    input  wire                        empty,
    output logic                       pop,
    output amac_xfer_pkg::result_t     res,
    output logic                       res_req,
    input  wire                        res_ack
);

    amac_arith_pkg::acc_t acc;
    amac_arith_pkg::acc_t prod_ext;
    amac_arith_pkg::acc_t acc_next;

    // only pop when the previous handshake has fully returned to zero
    assign pop = !empty && !res_req && !res_ack;

    assign prod_ext = {{(`AMAC_ACC_W - `AMAC_PROD_W){pop_data.product[`AMAC_PROD_W-1]}},
                       pop_data.product};

    always_comb begin
        if (pop_data.opcode == amac_xfer_pkg::OP_MAC) begin
            // wraps modulo 2^40
            acc_next = acc + prod_ext;
        end else begin
            acc_next = prod_ext;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else if (pop) begin
            acc <= acc_next;
        end
    end

    // result word, held while req is high
    always_ff @(posedge clk) begin
        if (pop) begin
            res.value  <= acc_next;
            res.opcode <= pop_data.opcode;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_req <= 1'b0;
        end else if (pop) begin
            res_req <= 1'b1;
        end else if (res_ack) begin
            res_req <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/amac_top.sv */
`default_nettype none

module amac_top (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire amac_xfer_pkg::cmd_t     cmd,
    input  wire                          cmd_req,
    output wire                          cmd_ack,
    output wire amac_xfer_pkg::result_t  res,
    output wire                          res_req,
    input  wire                          res_ack
);

    wire                        push;
    wire amac_xfer_pkg::entry_t push_data;
    wire                        full;
    wire                        pop;
    wire amac_xfer_pkg::entry_t pop_data;
    wire                        empty;

    operand_front u_front (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd       (cmd),
        .cmd_req   (cmd_req),
        .cmd_ack   (cmd_ack),
        .full      (full),
        .push      (push),
        .push_data (push_data)
    );

    product_fifo u_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty)
    );

    accum_back u_back (
        .clk      (clk),
        .arst_n   (arst_n),
        .pop_data (pop_data),
        .empty    (empty),
        .pop      (pop),
        .res      (res),
        .res_req  (res_req),
        .res_ack  (res_ack)
    );

endmodule

`default_nettype wire

/* sim/amac_tb.sv */
`default_nettype none

module amac_tb;

    localparam int          CLK_PERIOD = 100;
    localparam int          MAX_ROWS   = 64;
    localparam logic [31:0] LFSR_SEED  = 32'hd9e6_8399;

    logic                   clk;
    logic                   arst_n;
    amac_xfer_pkg::cmd_t    cmd;
    logic                   cmd_req;
    logic                   cmd_ack;
    amac_xfer_pkg::result_t res;
    logic                   res_req;
    logic                   res_ack;

    // four words per row, opcode x y product
    logic [31:0] stim_words [MAX_ROWS*4];

    amac_xfer_pkg::opcode_e   row_op   [MAX_ROWS];
    amac_arith_pkg::operand_t row_x    [MAX_ROWS];
    amac_arith_pkg::operand_t row_y    [MAX_ROWS];
    amac_arith_pkg::product_t row_prod [MAX_ROWS];

    int   row_count    = 0;
    int   result_count = 0;
    logic rows_loaded  = 1'b0;
    logic reset_done   = 1'b0;
    logic sink_done    = 1'b0;
    logic stall_seen   = 1'b0;

    logic                   prev_req = 1'b0;
    amac_xfer_pkg::result_t prev_res;
    logic                   ack_at_edge = 1'b0;

    amac_top u_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .cmd     (cmd),
        .cmd_req (cmd_req),
        .cmd_ack (cmd_ack),
        .res     (res),
        .res_req (res_req),
        .res_ack (res_ack)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("ERROR %s expected 0x%h got 0x%h at time %0t", name, expected, actual, $time);
        $display("Simulation finished: FAIL");
        $fatal(1, "value check failed");
    endtask

    task automatic abort_run(input string reason);
        $display("%s at time %0t", reason, $time);
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted");
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int nbits, output int value);
        value = 0;
        for (int b = 0; b < nbits; b++) begin
            state = lfsr_step(state);
            value = (value << 1) | int'(state[0]);
        end
    endtask

    task automatic load_stimulus();
        logic [31:0] op_word;
        logic        found_end;
        found_end = 1'b0;
        $readmemh("sim/amac_stim.txt", stim_words);
        for (int r = 0; r < MAX_ROWS; r++) begin
            op_word = stim_words[4*r];
            if (!found_end) begin
                if (op_word === 32'hf) begin
                    found_end = 1'b1;
                end else if (op_word === 32'h0 || op_word === 32'h1) begin
                    row_op[r]   = amac_xfer_pkg::opcode_e'(op_word[0]);
                    row_x[r]    = stim_words[4*r+1][15:0];
                    row_y[r]    = stim_words[4*r+2][15:0];
                    row_prod[r] = stim_words[4*r+3];
                    row_count++;
                end else begin
                    abort_run($sformatf("stimulus row %0d has an unknown opcode", r));
                end
            end
        end
        if (!found_end || row_count == 0) begin
            abort_run("stimulus file is missing, empty or lacks its end row");
        end
    endtask

    // one full four-phase handshake, then an idle gap of 0 to 3 cycles
    task automatic send_command(input int r, inout logic [31:0] lfsr);
        int gap;
        int stall_cycles;
        cmd.opcode = row_op[r];
        cmd.x      = row_x[r];
        cmd.y      = row_y[r];
        cmd_req    = 1'b1;
        stall_cycles = 0;
        @(negedge clk);
        while (cmd_ack !== 1'b1) begin
            stall_cycles++;
            @(negedge clk);
        end
        if (stall_cycles > 0) begin
            stall_seen = 1'b1;
        end
        cmd_req = 1'b0;
        @(negedge clk);
        while (cmd_ack !== 1'b0) begin
            @(negedge clk);
        end
        draw_bits(lfsr, 2, gap);
        repeat (gap) @(negedge clk);
    endtask

    initial begin : main_proc
        logic [31:0] src_lfsr;
        src_lfsr = LFSR_SEED;
        arst_n   = 1'b0;
        cmd      = '0;
        cmd_req  = 1'b0;
        load_stimulus();
        rows_loaded = 1'b1;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        assert (cmd_ack == 1'b0) else report_mismatch("cmd_ack", 64'h0, {63'h0, cmd_ack});
        assert (res_req == 1'b0) else report_mismatch("res_req", 64'h0, {63'h0, res_req});
        reset_done = 1'b1;
        for (int r = 0; r < row_count; r++) begin
            send_command(r, src_lfsr);
        end
        wait (sink_done);
        // leave room for a stray extra result to show up
        repeat (10) @(negedge clk);
        @(posedge clk);
        assert (result_count == row_count)
            else report_mismatch("result_count", 64'(row_count), 64'(result_count));
        assert (stall_seen) else abort_run("cmd_ack was never held back by a full FIFO");
        if (result_count == row_count && stall_seen) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run("run ended with a failed end-of-run check");
        end
    end

    // result side, with its own model of the accumulator
    initial begin : sink_proc
        logic [31:0]          lfsr;
        amac_arith_pkg::acc_t model_acc;
        amac_arith_pkg::acc_t prod_ext;
        int                   delay;
        lfsr      = LFSR_SEED;
        model_acc = '0;
        res_ack   = 1'b0;
        wait (reset_done);
        for (int n = 0; n < row_count; n++) begin
            @(negedge clk);
            while (res_req !== 1'b1) begin
                @(negedge clk);
            end
            prod_ext = {{8{row_prod[n][31]}}, row_prod[n]};
            if (row_op[n] == amac_xfer_pkg::OP_MAC) begin
                model_acc = model_acc + prod_ext;
            end else begin
                model_acc = prod_ext;
            end
            assert (res.value == model_acc)
                else report_mismatch("res.value", {24'h0, model_acc}, {24'h0, res.value});
            assert (res.opcode == row_op[n])
                else report_mismatch("res.opcode", {63'h0, row_op[n]}, {63'h0, res.opcode});
            draw_bits(lfsr, 3, delay);
            repeat (delay) @(negedge clk);
            res_ack = 1'b1;
            @(negedge clk);
            while (res_req !== 1'b0) begin
                @(negedge clk);
            end
            draw_bits(lfsr, 3, delay);
            repeat (delay) @(negedge clk);
            res_ack = 1'b0;
        end
        sink_done = 1'b1;
    end

    // res_ack only moves on falling edges, so this is its value at the rising edge
    always @(posedge clk) begin
        ack_at_edge <= res_ack;
    end

    always @(negedge clk) begin
        if (reset_done) begin
            if (prev_req && res_req) begin
                assert (res == prev_res)
                    else report_mismatch("res", {23'h0, prev_res}, {23'h0, res});
            end
            if (!prev_req && res_req) begin
                assert (!ack_at_edge) else abort_run("res_req rose while res_ack was high");
                result_count++;
            end
        end
        prev_req <= res_req;
        prev_res <= res;
    end

    initial begin : watchdog
        wait (rows_loaded);
        #((row_count * 20 + 100) * CLK_PERIOD);
        abort_run($sformatf("timeout after %0d clock periods with %0d of %0d results",
                            row_count * 20 + 100, result_count, row_count));
    end

endmodule

`default_nettype wire

/* sim/amac_stim.txt */
// opcode (0 mul, 1 mac), x, y, expected approximate product, all hex
// a row with opcode f ends the list
0 0000 0000 00000000
0 0040 0001 00000040
1 0040 ffff ffffffc0
1 8000 8000 40000000
1 8000 8000 40000000
1 8000 8000 40000000
1 8000 8000 40000000
1 8000 7fff c0008000
0 8000 7fff c0008000
1 8000 7fff c0008000
1 ffc0 0005 fffffec0
0 0001 0001 00000000
1 000c 0003 00000010
0 1234 0000 00000000
0 0000 8000 00000000
0 7fc0 7fff 3fdf8040
1 7fc0 7fff 3fdf8040
1 0c40 1234 00defd00
1 f000 1234 fedcc000
0 8000 0001 ffff8000
1 8000 ffff 00008000
1 ffc0 ffc0 00001000
1 0100 8000 ff800000
0 0200 0200 00040000
1 fe00 0200 fffc0000
1 0040 7fff 001fffc0
1 0004 0002 00000008
0 0000 0000 00000000
f 0000 0000 00000000

/* files.f */
+incdir+source
source/amac_arith_pkg.sv
source/amac_xfer_pkg.sv
source/approx_signed_mult.sv
source/operand_front.sv
source/product_fifo.sv
source/accum_back.sv
source/amac_top.sv
sim/amac_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= amac_tb
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation finished: PASS
VFLAGS     ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

sim: build
	-$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass line not found in $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
